//--- build.f
+incdir+hw
+incdir+tests
hw/eth_tx_pkg.sv
hw/frame_check_sequence_generator.sv
hw/payload_buffer.sv
hw/fcs_appender.sv
hw/eth_tx_framer.sv
tests/tb_eth_tx_framer.sv

//--- hw/eth_tx_defines.svh
`ifndef ETH_TX_DEFINES_SVH
`define ETH_TX_DEFINES_SVH

// Payload buffer entries, also the upstream credits after reset
// and the longest frame allowed
`define ETH_TX_BUFFER_DEPTH 64

// Credits held toward downstream after reset
`define ETH_TX_OUT_CREDITS 16

// FCS words waiting in the appender
`define ETH_TX_FCS_QUEUE_DEPTH 4

// Minimum idle cycles between input frames
`define ETH_TX_FRAME_GAP 8

`endif

//--- hw/eth_tx_framer.sv
`timescale 1ns/1ps

module eth_tx_framer
    import eth_tx_pkg::*;
(
    input  logic  clock,
    input  logic  reset_n,
    input  byte_t in_data,
    input  logic  in_valid,
    input  logic  in_last,
    output logic  in_credit,
    input  logic  out_credit,
    output byte_t out_data,
    output logic  out_valid,
    output logic  out_last
);

    byte_t fcs_byte;
    logic  fcs_valid;
    byte_t buffer_data;
    logic  buffer_last;
    logic  buffer_empty;
    logic  buffer_pop;

    // CRC runs beside the buffer on the same input bytes
    frame_check_sequence_generator fcs_generator (
        .clock          (clock),
        .reset_n        (reset_n),
        .data           (in_data),
        .data_enable    (in_valid),
        .checksum       (fcs_byte),
        .checksum_valid (fcs_valid)
    );

    payload_buffer buffer (
        .clock     (clock),
        .reset_n   (reset_n),
        .data      (in_data),
        .valid     (in_valid),
        .last      (in_last),
        .pop       (buffer_pop),
        .head_data (buffer_data),
        .head_last (buffer_last),
        .empty     (buffer_empty),
        .credit    (in_credit)
    );

    fcs_appender appender (
        .clock      (clock),
        .reset_n    (reset_n),
        .fcs_byte   (fcs_byte),
        .fcs_valid  (fcs_valid),
        .head_data  (buffer_data),
        .head_last  (buffer_last),
        .empty      (buffer_empty),
        .pop        (buffer_pop),
        .out_credit (out_credit),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_last   (out_last)
    );

endmodule

//--- hw/eth_tx_pkg.sv
package eth_tx_pkg;

    // Payload or FCS byte
    typedef logic [7:0] byte_t;

    // CRC register and FCS word
    typedef logic [31:0] crc_t;

    // Downstream credit counter
    typedef logic [7:0] credit_count_t;

    // Buffer index plus wrap bit
    typedef logic [6:0] buffer_pointer_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_COMPUTE,
        S_FINISH
    } fcs_state_t;

    typedef enum logic {
        S_PAYLOAD,
        S_FCS
    } appender_state_t;

endpackage

//--- hw/fcs_appender.sv
`timescale 1ns/1ps

`include "eth_tx_defines.svh"

module fcs_appender
    import eth_tx_pkg::*;
(
    input  logic  clock,
    input  logic  reset_n,
    input  byte_t fcs_byte,
    input  logic  fcs_valid,
    input  byte_t head_data,
    input  logic  head_last,
    input  logic  empty,
    output logic  pop,
    input  logic  out_credit,
    output byte_t out_data,
    output logic  out_valid,
    output logic  out_last
);

    localparam int QUEUE_INDEX_WIDTH = $clog2(`ETH_TX_FCS_QUEUE_DEPTH);

    appender_state_t              state;
    credit_count_t                credits;
    crc_t                         fcs_queue [`ETH_TX_FCS_QUEUE_DEPTH];
    logic [QUEUE_INDEX_WIDTH:0]   queue_write_pointer;
    logic [QUEUE_INDEX_WIDTH:0]   queue_read_pointer;
    crc_t                         gather_word;
    logic [1:0]                   gather_count;
    logic [1:0]                   fcs_index;
    logic                         credit_available;
    logic                         fcs_ready;
    logic                         fcs_send;
    logic                         send;
    byte_t                        fcs_out_byte;

    ////////////////////////////////////////////////////////////////////////////
    // FCS gathering

    always_ff @(posedge clock) begin
        if (fcs_valid) begin
            gather_word <= {fcs_byte, gather_word[31:8]};
            if (gather_count == 2'd3) begin
                fcs_queue[queue_write_pointer[QUEUE_INDEX_WIDTH-1:0]] <=
                    {fcs_byte, gather_word[31:8]};
            end
        end
    end

    always_comb begin
        credit_available = (credits != '0);
        fcs_ready        = (queue_write_pointer != queue_read_pointer);
        pop              = (state == S_PAYLOAD) && credit_available && !empty;
        fcs_send         = (state == S_FCS) && credit_available && fcs_ready;
        send             = pop || fcs_send;
        fcs_out_byte     = fcs_queue[queue_read_pointer[QUEUE_INDEX_WIDTH-1:0]]
                               [{fcs_index, 3'b000} +: 8];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Send control and credits

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state               <= S_PAYLOAD;
            credits             <= credit_count_t'(`ETH_TX_OUT_CREDITS);
            queue_write_pointer <= '0;
            queue_read_pointer  <= '0;
            gather_count        <= 2'd0;
            fcs_index           <= 2'd0;
            out_valid           <= 1'b0;
            out_last            <= 1'b0;
        end else begin
            if (fcs_valid) begin
                gather_count <= gather_count + 2'd1;
                if (gather_count == 2'd3) begin
                    queue_write_pointer <= queue_write_pointer + 1'b1;
                end
            end

            case ({out_credit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase

            out_valid <= send;
            out_last  <= fcs_send && (fcs_index == 2'd3);

            if (pop && head_last) begin
                state     <= S_FCS;
                fcs_index <= 2'd0;
            end
            if (fcs_send) begin
                fcs_index <= fcs_index + 2'd1;
                // Word done, release the queue entry
                if (fcs_index == 2'd3) begin
                    queue_read_pointer <= queue_read_pointer + 1'b1;
                    state              <= S_PAYLOAD;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            out_data <= head_data;
        end else if (fcs_send) begin
            out_data <= fcs_out_byte;
        end
    end

endmodule

//--- hw/frame_check_sequence_generator.sv
`timescale 1ns/1ps

module frame_check_sequence_generator
    import eth_tx_pkg::*;
(
    input  logic  clock,
    input  logic  reset_n,
    input  byte_t data,
    input  logic  data_enable,
    output byte_t checksum,
    output logic  checksum_valid
);

    localparam crc_t CRC_POLYNOMIAL = 32'h04C1_1DB7;
    localparam crc_t CRC_SEED       = 32'hFFFF_FFFF;

    fcs_state_t state;
    byte_t      data_reversed;
    byte_t      data_stage;
    logic       enable_stage;
    crc_t       crc;
    crc_t       crc_next;
    crc_t       fcs_word;
    crc_t       fcs_shift;
    logic [1:0] byte_counter;

    // Advance the normal-order CRC by one byte, MSB first
    function automatic crc_t crc_advance(input crc_t current, input byte_t value);
        crc_t result;
        logic feedback;
        result = current;
        for (int i = 7; i >= 0; i--) begin
            feedback = result[31] ^ value[i];
            result   = {result[30:0], 1'b0};
            if (feedback) begin
                result = result ^ CRC_POLYNOMIAL;
            end
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bit reversal in and out

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            data_reversed[i] = data[7 - i];
        end
        crc_next = crc_advance(crc, data_stage);
        // Reflect and invert to get the wire order FCS
        for (int i = 0; i < 32; i++) begin
            fcs_word[i] = ~crc[31 - i];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state          <= S_IDLE;
            enable_stage   <= 1'b0;
            crc            <= CRC_SEED;
            byte_counter   <= 2'd0;
            checksum_valid <= 1'b0;
        end else begin
            enable_stage   <= data_enable;
            checksum_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (enable_stage) begin
                        crc   <= crc_next;
                        state <= S_COMPUTE;
                    end
                end
                S_COMPUTE: begin
                    if (enable_stage) begin
                        crc <= crc_next;
                    end else begin
                        // Byte 0 leaves on the way into FINISH
                        checksum_valid <= 1'b1;
                        byte_counter   <= 2'd1;
                        state          <= S_FINISH;
                    end
                end
                S_FINISH: begin
                    checksum_valid <= 1'b1;
                    byte_counter   <= byte_counter + 2'd1;
                    crc            <= CRC_SEED;
                    if (byte_counter == 2'd3) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath

    always_ff @(posedge clock) begin
        data_stage <= data_reversed;
        if (state == S_COMPUTE && !enable_stage) begin
            checksum  <= fcs_word[7:0];
            fcs_shift <= fcs_word >> 8;
        end else if (state == S_FINISH) begin
            checksum  <= fcs_shift[7:0];
            fcs_shift <= fcs_shift >> 8;
        end
    end

endmodule

//--- hw/payload_buffer.sv
`timescale 1ns/1ps

`include "eth_tx_defines.svh"

module payload_buffer
    import eth_tx_pkg::*;
(
    input  logic  clock,
    input  logic  reset_n,
    input  byte_t data,
    input  logic  valid,
    input  logic  last,
    input  logic  pop,
    output byte_t head_data,
    output logic  head_last,
    output logic  empty,
    output logic  credit
);

    localparam int INDEX_WIDTH = $clog2(`ETH_TX_BUFFER_DEPTH);

    byte_t           data_memory [`ETH_TX_BUFFER_DEPTH];
    logic            last_memory [`ETH_TX_BUFFER_DEPTH];
    buffer_pointer_t write_pointer;
    buffer_pointer_t read_pointer;
    logic            pop_accepted;

    ////////////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clock) begin
        if (valid) begin
            data_memory[write_pointer[INDEX_WIDTH-1:0]] <= data;
            last_memory[write_pointer[INDEX_WIDTH-1:0]] <= last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers

    // No full check, upstream credits bound the fill level
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
        end else begin
            if (valid) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (pop_accepted) begin
                read_pointer <= read_pointer + 1'b1;
            end
        end
    end

    // Head entry shows one cycle after its push
    assign head_data = data_memory[read_pointer[INDEX_WIDTH-1:0]];
    assign head_last = last_memory[read_pointer[INDEX_WIDTH-1:0]];

    // Equal pointers including wrap bit
    assign empty = (write_pointer == read_pointer);

    assign pop_accepted = pop && !empty;

    // Freed slot goes straight back upstream
    assign credit = pop_accepted;

endmodule

//--- tests/eth_tx_checks.svh
`ifndef ETH_TX_CHECKS_SVH
`define ETH_TX_CHECKS_SVH

`include "eth_tx_defines.svh"

// Expected output bytes as {last, data}
logic [8:0] expected_bytes[$];
int         frames_pending = 0;

// Upstream side
int upstream_credits = `ETH_TX_BUFFER_DEPTH;
int credits_returned = 0;
int bytes_sent       = 0;

// Downstream side, bytes_owed is what the sink still has to return
int downstream_credits = `ETH_TX_OUT_CREDITS;
int bytes_owed         = 0;

// Reflected CRC-32, one byte, LSB first
function automatic crc_t crc_step(input crc_t current, input byte_t value);
    crc_t result;
    result = current ^ {24'h0, value};
    for (int i = 0; i < 8; i++) begin
        if (result[0]) begin
            result = (result >> 1) ^ 32'hEDB8_8320;
        end else begin
            result = result >> 1;
        end
    end
    return result;
endfunction

task automatic expect_payload(input byte_t value);
    expected_bytes.push_back({1'b0, value});
endtask

// FCS goes out least significant byte first, last flag on the fourth
task automatic expect_fcs(input crc_t fcs);
    logic is_last;
    for (int i = 0; i < 4; i++) begin
        is_last = (i == 3);
        expected_bytes.push_back({is_last, fcs[8*i +: 8]});
    end
endtask

`endif

//--- tests/tb_eth_tx_framer.sv
`timescale 1ns/1ps

`include "eth_tx_defines.svh"

module tb_eth_tx_framer
    import eth_tx_pkg::*;
();

    logic  clock;
    logic  reset_n;
    byte_t in_data;
    logic  in_valid;
    logic  in_last;
    logic  in_credit;
    logic  out_credit;
    byte_t out_data;
    logic  out_valid;
    logic  out_last;

    integer seed            = 32'hebd5e979;
    string  test_name       = "reset";
    int     watchdog_cycles = 0;
    logic   withhold_credit = 1'b0;
    byte_t  payload_pool[$];
    int     random_lengths[12];
    int     stall_lengths[3];

    `include "eth_tx_checks.svh"

    eth_tx_framer dut (
        .clock      (clock),
        .reset_n    (reset_n),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_last   (out_last)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, expected, actual);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string reason);
        $display("Error in test %s: %s", test_name, reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_idle_outputs();
        assert (out_valid === 1'b0) else report_mismatch("out_valid", 0, out_valid);
        assert (out_last === 1'b0) else report_mismatch("out_last", 0, out_last);
        assert (in_credit === 1'b0) else report_mismatch("in_credit", 0, in_credit);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Frame driver that starts and ends 1 ns after a rising edge

    task automatic send_frame(input int length, input logic known_vector);
        crc_t  crc;
        byte_t value;
        while (upstream_credits < length || frames_pending >= `ETH_TX_FCS_QUEUE_DEPTH) begin
            @(posedge clock);
            #1;
        end
        frames_pending++;
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < length; i++) begin
            value = known_vector ? byte_t'(8'h31 + i) : payload_pool.pop_front();
            in_data  = value;
            in_valid = 1'b1;
            in_last  = (i == length - 1);
            expect_payload(value);
            crc = crc_step(crc, value);
            bytes_sent++;
            @(posedge clock);
            #1;
        end
        // "123456789" has the published check value
        expect_fcs(known_vector ? 32'hCBF4_3926 : ~crc);
        in_valid = 1'b0;
        in_last  = 1'b0;
        repeat (`ETH_TX_FRAME_GAP) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic wait_for_drain();
        while (expected_bytes.size() != 0 || frames_pending != 0) begin
            @(posedge clock);
            #1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    initial begin : stimulus
        crc_t reference;
        int   total_bytes;
        in_data    = '0;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        out_credit = 1'b0;
        reset_n    = 1'b0;
        total_bytes = 9 + 1 + `ETH_TX_BUFFER_DEPTH + 1;
        foreach (random_lengths[i]) begin
            random_lengths[i] = 1 + ($unsigned($random(seed)) % `ETH_TX_BUFFER_DEPTH);
            total_bytes += random_lengths[i];
        end
        // Stalled frames outlast the downstream credits yet fit in the buffer
        foreach (stall_lengths[i]) begin
            stall_lengths[i] = 8 + ($unsigned($random(seed)) % 13);
            total_bytes += stall_lengths[i];
        end
        for (int i = 0; i < total_bytes - 9; i++) begin
            payload_pool.push_back(byte_t'($random(seed)));
        end
        watchdog_cycles = total_bytes * 20 + 2000;
        reference = 32'hFFFF_FFFF;
        for (int i = 0; i < 9; i++) begin
            reference = crc_step(reference, byte_t'(8'h31 + i));
        end
        assert (~reference == 32'hCBF4_3926)
            else report_mismatch("reference CRC-32", 32'hCBF4_3926, ~reference);
        repeat (5) begin
            @(posedge clock);
            #1;
            check_idle_outputs();
        end
        reset_n = 1'b1;
        @(posedge clock);
        #1;
        check_idle_outputs();
        test_name = "known_vector";
        send_frame(9, 1'b1);
        test_name = "min_gap";
        send_frame(1, 1'b0);
        send_frame(`ETH_TX_BUFFER_DEPTH, 1'b0);
        send_frame(1, 1'b0);
        test_name = "random_frames";
        foreach (random_lengths[i]) begin
            send_frame(random_lengths[i], 1'b0);
        end
        wait_for_drain();
        test_name = "credit_stall";
        withhold_credit = 1'b1;
        foreach (stall_lengths[i]) begin
            send_frame(stall_lengths[i], 1'b0);
        end
        repeat (200) @(posedge clock);
        #1;
        withhold_credit = 1'b0;
        test_name = "drain";
        wait_for_drain();
        assert (upstream_credits == `ETH_TX_BUFFER_DEPTH)
            else report_mismatch("upstream credits", `ETH_TX_BUFFER_DEPTH, upstream_credits);
        assert (credits_returned == bytes_sent)
            else report_mismatch("in_credit pulses", bytes_sent, credits_returned);
        $display("Simulation completed successfully");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Downstream sink returns credits at random

    initial begin : downstream_credit_return
        logic hold;
        forever begin
            @(posedge clock);
            hold = withhold_credit;
            #1;
            if (bytes_owed > 0 && !hold && ($random(seed) & 1) == 1) begin
                out_credit = 1'b1;
                bytes_owed--;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard and credit models

    always @(posedge clock) begin : output_monitor
        logic [8:0] entry;
        if (reset_n) begin
            if (in_valid) upstream_credits--;
            if (in_credit) begin
                upstream_credits++;
                credits_returned++;
            end
            assert (upstream_credits >= 0 && upstream_credits <= `ETH_TX_BUFFER_DEPTH)
                else abort_run("upstream credit count left its valid range");
            assert (!out_last || out_valid) else abort_run("out_last high without out_valid");
            if (out_valid) begin
                assert (downstream_credits > 0)
                    else abort_run("out_valid high while downstream held no credit");
                assert (expected_bytes.size() != 0)
                    else abort_run("output byte arrived with no byte expected");
                entry = expected_bytes.pop_front();
                assert (out_data === entry[7:0])
                    else report_mismatch("out_data", entry[7:0], out_data);
                assert (out_last === entry[8])
                    else report_mismatch("out_last", entry[8], out_last);
                downstream_credits--;
                bytes_owed++;
                if (out_last) frames_pending--;
            end
            if (out_credit) downstream_credits++;
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        abort_run("timed out before all frames drained");
    end

endmodule
